// ==== mm_ram_top.f ====
logic/mm_pkg.sv
logic/mm_ifs.sv
logic/mm_sram.sv
logic/mm_instr_port.sv
logic/mm_data_port.sv
logic/mm_periph_regs.sv
logic/mm_ram_top.sv
verif/mm_ram_props.sv
verif/mm_ram_tb.sv

// ==== Bender.yml ====
package:
  name: mm_ram

sources:
  - logic/mm_pkg.sv
  - logic/mm_ifs.sv
  - logic/mm_sram.sv
  - logic/mm_instr_port.sv
  - logic/mm_data_port.sv
  - logic/mm_periph_regs.sv
  - logic/mm_ram_top.sv
  - target: test
    files:
      - verif/mm_ram_props.sv
      - verif/mm_ram_tb.sv

// ==== verif/mm_ram_tb.sv ====
// ****************************************
// testbench for the RAM subsystem, LFSR
// stimulus, shadow model, watchdog
// ****************************************

`timescale 1ns/1ps
`default_nettype none

module mm_ram_tb;

    localparam int RAW          = 12;
    localparam int WORDS        = 2 ** (RAW - 2);
    localparam int CLK_NS       = 100;
    localparam int RESET_CYCLES = 16;
    // worst case bus steps over all phases including idles
    localparam int PLANNED      = 2100;
    localparam int WATCHDOG_NS  = (PLANNED * 4 + RESET_CYCLES) * CLK_NS;

    logic          clk;
    logic          rst_n;
    logic          instr_req;
    mm_pkg::word_t instr_addr;
    logic          instr_gnt;
    logic          instr_rvalid;
    mm_pkg::word_t instr_rdata;
    logic          data_req;
    mm_pkg::word_t data_addr;
    logic          data_we;
    mm_pkg::be_t   data_be;
    mm_pkg::word_t data_wdata;
    logic          data_gnt;
    logic          data_rvalid;
    mm_pkg::word_t data_rdata;
    logic          print_valid;
    logic [7:0]    print_char;
    logic          tests_passed;
    logic          tests_failed;
    logic          exit_valid;
    mm_pkg::word_t exit_value;
    logic          debug_req;

    // reference model
    mm_pkg::word_t shadow [0:WORDS-1];
    mm_pkg::word_t instr_exp_q [$];
    mm_pkg::word_t data_exp_q [$];
    bit            data_chk_q [$];
    logic          passed_m;
    logic          failed_m;
    logic          exit_valid_m;
    mm_pkg::word_t exit_value_m;
    logic          print_m;
    logic [7:0]    char_m;
    // edge numbering for the debug pulse
    int            edge_cnt;
    int            fire_edge;
    logic [31:0]   lfsr_q;

    mm_ram_top #(
        .RAM_ADDR_WIDTH (RAW)
    ) UUT (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .instr_req_i    (instr_req),
        .instr_addr_i   (instr_addr),
        .instr_gnt_o    (instr_gnt),
        .instr_rvalid_o (instr_rvalid),
        .instr_rdata_o  (instr_rdata),
        .data_req_i     (data_req),
        .data_addr_i    (data_addr),
        .data_we_i      (data_we),
        .data_be_i      (data_be),
        .data_wdata_i   (data_wdata),
        .data_gnt_o     (data_gnt),
        .data_rvalid_o  (data_rvalid),
        .data_rdata_o   (data_rdata),
        .print_valid_o  (print_valid),
        .print_char_o   (print_char),
        .tests_passed_o (tests_passed),
        .tests_failed_o (tests_failed),
        .exit_valid_o   (exit_valid),
        .exit_value_o   (exit_value),
        .debug_req_o    (debug_req)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // ends a hung run
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog timeout");
    end

    // fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic mm_pkg::word_t rand_bits(input int n);
        mm_pkg::word_t r;
        logic          fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r      = {r[30:0], fb};
        end
        return r;
    endfunction

    // address map as the model sees it
    function automatic mm_pkg::sel_e target_of(input mm_pkg::word_t a);
        if (a < (mm_pkg::word_t'(1) << RAW)) return mm_pkg::SEL_RAM;
        if (a == mm_pkg::PRINT_ADDR) return mm_pkg::SEL_PRINT;
        if (a == mm_pkg::STATUS_ADDR) return mm_pkg::SEL_STATUS;
        if (a == mm_pkg::EXIT_ADDR) return mm_pkg::SEL_EXIT;
        if (a == mm_pkg::DEBUG_ADDR) return mm_pkg::SEL_DEBUG;
        return mm_pkg::SEL_NONE;
    endfunction

    task automatic fail_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_word(input string name, input mm_pkg::word_t act,
                              input mm_pkg::word_t exp);
        if (act !== exp) begin
            $display("** Error at %0d ns: %s = %h, expected %h", $time, name, act, exp);
            fail_run();
        end
    endtask

    task automatic check_bit(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            $display("** Error at %0d ns: %s = %b, expected %b", $time, name, act, exp);
            fail_run();
        end
    endtask

    task automatic check_char(input string name, input logic [7:0] act,
                              input logic [7:0] exp);
        if (act !== exp) begin
            $display("** Error at %0d ns: %s = %h, expected %h", $time, name, act, exp);
            fail_run();
        end
    endtask

    // model side of a granted data write
    task automatic apply_write(input mm_pkg::sel_e sel, input int idx,
                               input mm_pkg::be_t be, input mm_pkg::word_t wd);
        case (sel)
            mm_pkg::SEL_RAM: begin
                for (int b = 0; b < 4; b++) begin
                    if (be[b]) shadow[idx][8*b +: 8] = wd[8*b +: 8];
                end
            end
            mm_pkg::SEL_PRINT: begin
                print_m = 1'b1;
                char_m  = wd[7:0];
            end
            mm_pkg::SEL_STATUS: begin
                if (wd == mm_pkg::TEST_PASS_MAGIC) passed_m = 1'b1;
                if (wd == mm_pkg::TEST_FAIL_MAGIC) failed_m = 1'b1;
            end
            mm_pkg::SEL_EXIT: begin
                exit_valid_m = 1'b1;
                exit_value_m = wd;
            end
            // zero cancels and anything else restarts
            mm_pkg::SEL_DEBUG: fire_edge = (wd == '0) ? -1 : edge_cnt + int'(wd);
            default: ;
        endcase
    endtask

    // responses and peripheral outputs after one edge
    task automatic compare_outputs();
        mm_pkg::word_t exp;
        bit            chk;
        check_bit("instr_rvalid_o", instr_rvalid, instr_exp_q.size() != 0);
        if (instr_exp_q.size() != 0) begin
            exp = instr_exp_q.pop_front();
            check_word("instr_rdata_o", instr_rdata, exp);
        end
        check_bit("data_rvalid_o", data_rvalid, data_exp_q.size() != 0);
        if (data_exp_q.size() != 0) begin
            exp = data_exp_q.pop_front();
            chk = data_chk_q.pop_front();
            if (chk) check_word("data_rdata_o", data_rdata, exp);
        end
        check_bit("print_valid_o", print_valid, print_m);
        if (print_m) check_char("print_char_o", print_char, char_m);
        check_bit("tests_passed_o", tests_passed, passed_m);
        check_bit("tests_failed_o", tests_failed, failed_m);
        check_bit("exit_valid_o", exit_valid, exit_valid_m);
        if (exit_valid_m) check_word("exit_value_o", exit_value, exit_value_m);
        check_bit("debug_req_o", debug_req, edge_cnt == fire_edge);
        if (UUT.props_i.fail_cnt != 0) begin
            $display("a bound assertion on the DUT failed before %0d ns", $time);
            fail_run();
        end
    endtask

    // one clock of both ports from the falling edge
    task automatic step(input logic ireq, input mm_pkg::word_t iaddr,
                        input logic dreq, input mm_pkg::word_t daddr,
                        input logic dwe, input mm_pkg::be_t dbe,
                        input mm_pkg::word_t dwdata);
        mm_pkg::sel_e  sel;
        mm_pkg::word_t exp;
        int            idx;
        instr_req  = ireq;
        instr_addr = iaddr;
        data_req   = dreq;
        data_addr  = daddr;
        data_we    = dwe;
        data_be    = dbe;
        data_wdata = dwdata;
        edge_cnt++;
        sel     = target_of(daddr);
        idx     = int'(daddr[RAW-1:2]);
        print_m = 1'b0;
        // fetch sees the word as it was before a same edge write
        if (ireq) instr_exp_q.push_back(shadow[iaddr[RAW-1:2]]);
        if (dreq) begin
            case (sel)
                mm_pkg::SEL_RAM:    exp = shadow[idx];
                mm_pkg::SEL_STATUS: exp = {30'd0, failed_m, passed_m};
                mm_pkg::SEL_EXIT:   exp = exit_value_m;
                default:            exp = '0;
            endcase
            data_exp_q.push_back(exp);
            // write responses and debug counts not compared
            data_chk_q.push_back(!dwe && (sel != mm_pkg::SEL_DEBUG));
            if (dwe) apply_write(sel, idx, dbe, dwdata);
        end
        #1;
        check_bit("instr_gnt_o", instr_gnt, ireq);
        check_bit("data_gnt_o", data_gnt, dreq);
        @(negedge clk);
        compare_outputs();
    endtask

    task automatic idle();
        step(1'b0, '0, 1'b0, '0, 1'b0, '0, '0);
    endtask

    task automatic data_write(input mm_pkg::word_t a, input mm_pkg::word_t d);
        step(1'b0, '0, 1'b1, a, 1'b1, 4'hf, d);
    endtask

    task automatic data_read(input mm_pkg::word_t a);
        step(1'b0, '0, 1'b1, a, 1'b0, 4'hf, '0);
    endtask

    initial begin
        logic          dr;
        logic          dw;
        logic          ir;
        mm_pkg::word_t da;
        mm_pkg::word_t ia;
        mm_pkg::word_t dd;
        mm_pkg::word_t ua;
        mm_pkg::be_t   db;
        int            n;
        lfsr_q       = 32'hf6f3_766c;
        edge_cnt     = 0;
        fire_edge    = -1;
        passed_m     = 1'b0;
        failed_m     = 1'b0;
        exit_valid_m = 1'b0;
        print_m      = 1'b0;
        rst_n        = 1'b0;
        instr_req    = 1'b0;
        instr_addr   = '0;
        data_req     = 1'b0;
        data_addr    = '0;
        data_we      = 1'b0;
        data_be      = '0;
        data_wdata   = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        // fill every word so later reads are defined
        for (int i = 0; i < WORDS; i++) begin
            dd = rand_bits(32);
            data_write(mm_pkg::word_t'(i) << 2, dd);
        end

        // random RAM traffic and gaps on both ports
        for (int i = 0; i < 600; i++) begin
            dr = rand_bits(2) != 0;
            dw = rand_bits(1) != 0;
            da = rand_bits(RAW - 2) << 2;
            db = mm_pkg::be_t'(rand_bits(4));
            dd = rand_bits(32);
            ir = rand_bits(2) != 0;
            // fetch often hits the data word through an alias
            if (rand_bits(1) != 0) ia = da | (rand_bits(32 - RAW) << RAW);
            else ia = rand_bits(32) & ~32'h3;
            step(ir, ia, dr, da, dw, db, dd);
        end

        // unmapped writes leave the aliased RAM word alone
        for (int i = 0; i < 40; i++) begin
            ua = rand_bits(32) | 32'h4000_0000;
            dd = rand_bits(32);
            data_write(ua, dd);
            data_read(ua);
            step(1'b1, ua, 1'b1, ua & mm_pkg::word_t'((1 << RAW) - 4), 1'b0, 4'hf, '0);
        end

        // stdout with a gap after each char
        for (int i = 0; i < 20; i++) begin
            dd = rand_bits(32);
            n  = int'(rand_bits(2)) + 1;
            data_write(mm_pkg::PRINT_ADDR, dd);
            repeat (n) idle();
        end
        data_read(mm_pkg::PRINT_ADDR);

        // status and exit
        dd = rand_bits(32) | 32'h8000_0000;
        data_write(mm_pkg::STATUS_ADDR, dd);
        data_read(mm_pkg::STATUS_ADDR);
        data_write(mm_pkg::STATUS_ADDR, mm_pkg::TEST_PASS_MAGIC);
        data_read(mm_pkg::STATUS_ADDR);
        dd = rand_bits(32);
        data_write(mm_pkg::EXIT_ADDR, dd);
        data_read(mm_pkg::EXIT_ADDR);
        idle();

        // plain debug countdowns
        for (int i = 0; i < 8; i++) begin
            n = int'(rand_bits(5)) % 20 + 1;
            data_write(mm_pkg::DEBUG_ADDR, mm_pkg::word_t'(n));
            repeat (n + 3) idle();
        end
        // rewrite mid count
        data_write(mm_pkg::DEBUG_ADDR, 32'd10);
        repeat (4) idle();
        n = int'(rand_bits(5)) % 20 + 1;
        data_write(mm_pkg::DEBUG_ADDR, mm_pkg::word_t'(n));
        repeat (n + 3) idle();
        // zero cancels
        data_write(mm_pkg::DEBUG_ADDR, 32'd8);
        repeat (3) idle();
        data_write(mm_pkg::DEBUG_ADDR, 32'd0);
        repeat (12) idle();

        if (UUT.props_i.fail_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/mm_ram_props.sv ====
// ****************************************
// handshake and pulse assertions, bound
// to the RAM subsystem top
// ****************************************

`timescale 1ns/1ps
`default_nettype none

module mm_ram_props (
    input logic clk_i,
    input logic rst_n_i,
    input logic instr_req_i,
    input logic instr_gnt_o,
    input logic instr_rvalid_o,
    input logic data_req_i,
    input logic data_gnt_o,
    input logic data_rvalid_o,
    input logic print_valid_o,
    input logic tests_passed_o,
    input logic tests_failed_o,
    input logic exit_valid_o,
    input logic debug_req_o
);

    // failures seen so far
    int fail_cnt = 0;

    // grant in the request cycle, reset too
    instr_gnt_a: assert property (@(posedge clk_i) instr_gnt_o == instr_req_i)
        else begin
            fail_cnt++;
            $error("instr_gnt_o does not follow instr_req_i");
        end
    data_gnt_a: assert property (@(posedge clk_i) data_gnt_o == data_req_i)
        else begin
            fail_cnt++;
            $error("data_gnt_o does not follow data_req_i");
        end

    // response exactly one cycle after an accepted grant
    instr_rvalid_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        instr_rvalid_o == ($past(instr_gnt_o) && $past(rst_n_i)))
        else begin
            fail_cnt++;
            $error("instr_rvalid_o not one cycle after a grant");
        end
    data_rvalid_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        data_rvalid_o == ($past(data_gnt_o) && $past(rst_n_i)))
        else begin
            fail_cnt++;
            $error("data_rvalid_o not one cycle after a grant");
        end

    // single cycle pulses
    print_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        print_valid_o |=> !print_valid_o)
        else begin
            fail_cnt++;
            $error("print_valid_o high for more than one cycle");
        end
    debug_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        debug_req_o |=> !debug_req_o)
        else begin
            fail_cnt++;
            $error("debug_req_o high for more than one cycle");
        end

    // everything quiet once reset has taken an edge
    reset_low_a: assert property (@(posedge clk_i) !rst_n_i |=>
        !(instr_rvalid_o || data_rvalid_o || print_valid_o || debug_req_o ||
          tests_passed_o || tests_failed_o || exit_valid_o))
        else begin
            fail_cnt++;
            $error("an output is high after reset");
        end

endmodule

bind mm_ram_top mm_ram_props props_i (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .instr_req_i    (instr_req_i),
    .instr_gnt_o    (instr_gnt_o),
    .instr_rvalid_o (instr_rvalid_o),
    .data_req_i     (data_req_i),
    .data_gnt_o     (data_gnt_o),
    .data_rvalid_o  (data_rvalid_o),
    .print_valid_o  (print_valid_o),
    .tests_passed_o (tests_passed_o),
    .tests_failed_o (tests_failed_o),
    .exit_valid_o   (exit_valid_o),
    .debug_req_o    (debug_req_o)
);

`default_nettype wire

// ==== logic/mm_ram_top.sv ====
// ****************************************
// RAM subsystem top, instruction and data
// ports, shared RAM, pseudo peripherals
// ****************************************

`timescale 1ns/1ps
`default_nettype none

module mm_ram_top #(
    parameter int RAM_ADDR_WIDTH = 12
) (
    input  logic          clk_i,
    input  logic          rst_n_i,

    input  logic          instr_req_i,
    input  mm_pkg::word_t instr_addr_i,
    output logic          instr_gnt_o,
    output logic          instr_rvalid_o,
    output mm_pkg::word_t instr_rdata_o,

    input  logic          data_req_i,
    input  mm_pkg::word_t data_addr_i,
    input  logic          data_we_i,
    input  mm_pkg::be_t   data_be_i,
    input  mm_pkg::word_t data_wdata_i,
    output logic          data_gnt_o,
    output logic          data_rvalid_o,
    output mm_pkg::word_t data_rdata_o,

    output logic          print_valid_o,
    output logic [7:0]    print_char_o,
    output logic          tests_passed_o,
    output logic          tests_failed_o,
    output logic          exit_valid_o,
    output mm_pkg::word_t exit_value_o,
    output logic          debug_req_o
);

    mm_bus_if instr_bus ();
    mm_bus_if data_bus ();
    mm_sram_if #(.RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)) i_sram ();
    mm_sram_if #(.RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)) d_sram ();

    // data port to peripheral block
    logic          per_wr;
    mm_pkg::sel_e  per_sel;
    mm_pkg::word_t per_wdata;
    mm_pkg::word_t per_rdata;

    // instruction side, read only
    assign instr_bus.req   = instr_req_i;
    assign instr_bus.addr  = instr_addr_i;
    assign instr_bus.we    = 1'b0;
    assign instr_bus.be    = '1;
    assign instr_bus.wdata = '0;
    assign instr_gnt_o     = instr_bus.gnt;
    assign instr_rvalid_o  = instr_bus.rvalid;
    assign instr_rdata_o   = instr_bus.rdata;

    // data side
    assign data_bus.req   = data_req_i;
    assign data_bus.addr  = data_addr_i;
    assign data_bus.we    = data_we_i;
    assign data_bus.be    = data_be_i;
    assign data_bus.wdata = data_wdata_i;
    assign data_gnt_o     = data_bus.gnt;
    assign data_rvalid_o  = data_bus.rvalid;
    assign data_rdata_o   = data_bus.rdata;

    mm_instr_port #(
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
    ) instr_port_i (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .bus     (instr_bus),
        .mem     (i_sram)
    );

    mm_data_port #(
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
    ) data_port_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .bus         (data_bus),
        .mem         (d_sram),
        .per_wr_o    (per_wr),
        .per_sel_o   (per_sel),
        .per_wdata_o (per_wdata),
        .per_rdata_i (per_rdata)
    );

    mm_sram #(
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
    ) sram_i (
        .clk_i  (clk_i),
        .i_port (i_sram),
        .d_port (d_sram)
    );

    mm_periph_regs periph_i (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .wr_i           (per_wr),
        .sel_i          (per_sel),
        .wdata_i        (per_wdata),
        .rdata_o        (per_rdata),
        .print_valid_o  (print_valid_o),
        .print_char_o   (print_char_o),
        .tests_passed_o (tests_passed_o),
        .tests_failed_o (tests_failed_o),
        .exit_valid_o   (exit_valid_o),
        .exit_value_o   (exit_value_o),
        .debug_req_o    (debug_req_o)
    );

endmodule

`default_nettype wire

// ==== logic/mm_periph_regs.sv ====
// ****************************************
// stdout, test status, exit value and
// debug request timer registers
// ****************************************

`timescale 1ns/1ps
`default_nettype none

module mm_periph_regs (
    input  logic          clk_i,
    input  logic          rst_n_i,
    input  logic          wr_i,
    input  mm_pkg::sel_e  sel_i,
    input  mm_pkg::word_t wdata_i,
    output mm_pkg::word_t rdata_o,
    output logic          print_valid_o,
    output logic [7:0]    print_char_o,
    output logic          tests_passed_o,
    output logic          tests_failed_o,
    output logic          exit_valid_o,
    output mm_pkg::word_t exit_value_o,
    output logic          debug_req_o
);

    mm_pkg::dbg_state_e dbg_state_q;
    mm_pkg::word_t      dbg_cnt_q;

    // per target write strobes
    logic wr_print;
    logic wr_status;
    logic wr_exit;
    logic wr_debug;

    assign wr_print  = wr_i && (sel_i == mm_pkg::SEL_PRINT);
    assign wr_status = wr_i && (sel_i == mm_pkg::SEL_STATUS);
    assign wr_exit   = wr_i && (sel_i == mm_pkg::SEL_EXIT);
    assign wr_debug  = wr_i && (sel_i == mm_pkg::SEL_DEBUG);

    // stdout strobe and status / exit flags
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            print_valid_o  <= 1'b0;
            tests_passed_o <= 1'b0;
            tests_failed_o <= 1'b0;
            exit_valid_o   <= 1'b0;
        end else begin
            // one cycle per print write
            print_valid_o <= wr_print;
            // sticky, non magic values ignored
            if (wr_status && (wdata_i == mm_pkg::TEST_PASS_MAGIC)) begin
                tests_passed_o <= 1'b1;
            end
            if (wr_status && (wdata_i == mm_pkg::TEST_FAIL_MAGIC)) begin
                tests_failed_o <= 1'b1;
            end
            if (wr_exit) begin
                exit_valid_o <= 1'b1;
            end
        end
    end

    // payload registers
    always_ff @(posedge clk_i) begin
        if (wr_print) begin
            print_char_o <= wdata_i[7:0];
        end
        if (wr_exit) begin
            exit_value_o <= wdata_i;
        end
    end

    // debug countdown, a write restarts or cancels it
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            dbg_state_q <= mm_pkg::DBG_IDLE;
            dbg_cnt_q   <= '0;
        end else if (wr_debug) begin
            dbg_cnt_q   <= wdata_i;
            // zero cancels
            dbg_state_q <= (wdata_i == '0) ? mm_pkg::DBG_IDLE : mm_pkg::DBG_COUNT;
        end else begin
            case (dbg_state_q)
                mm_pkg::DBG_COUNT: begin
                    dbg_cnt_q <= dbg_cnt_q - 1'b1;
                    // last step, pulse lands N edges after the write
                    if (dbg_cnt_q == 32'd1) begin
                        dbg_state_q <= mm_pkg::DBG_FIRE;
                    end
                end
                mm_pkg::DBG_FIRE: dbg_state_q <= mm_pkg::DBG_IDLE;
                default:          dbg_state_q <= mm_pkg::DBG_IDLE;
            endcase
        end
    end

    assign debug_req_o = (dbg_state_q == mm_pkg::DBG_FIRE);

    // read values, print reads zero
    always_comb begin
        case (sel_i)
            mm_pkg::SEL_STATUS: rdata_o = {30'd0, tests_failed_o, tests_passed_o};
            mm_pkg::SEL_EXIT:   rdata_o = exit_value_o;
            mm_pkg::SEL_DEBUG:  rdata_o = dbg_cnt_q;
            default:            rdata_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/mm_data_port.sv ====
// ****************************************
// data port decode, handshake and read
// mux over RAM and peripherals
// ****************************************

`timescale 1ns/1ps
`default_nettype none

module mm_data_port #(
    parameter int RAM_ADDR_WIDTH = 12
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    mm_bus_if.slave         bus,
    mm_sram_if.ctrl         mem,
    output logic            per_wr_o,
    output mm_pkg::sel_e    per_sel_o,
    output mm_pkg::word_t   per_wdata_o,
    input  mm_pkg::word_t   per_rdata_i
);

    // first byte address past the RAM
    localparam mm_pkg::word_t RAM_LIMIT = mm_pkg::word_t'(1) << RAM_ADDR_WIDTH;

    mm_pkg::sel_e  sel_d;
    mm_pkg::sel_e  sel_q;
    logic          rvalid_q;
    mm_pkg::word_t per_rdata_q;

    // address decode, RAM window then exact peripheral match
    always_comb begin
        sel_d = mm_pkg::SEL_NONE;
        if (bus.addr < RAM_LIMIT) begin
            sel_d = mm_pkg::SEL_RAM;
        end else if (bus.addr == mm_pkg::PRINT_ADDR) begin
            sel_d = mm_pkg::SEL_PRINT;
        end else if (bus.addr == mm_pkg::STATUS_ADDR) begin
            sel_d = mm_pkg::SEL_STATUS;
        end else if (bus.addr == mm_pkg::EXIT_ADDR) begin
            sel_d = mm_pkg::SEL_EXIT;
        end else if (bus.addr == mm_pkg::DEBUG_ADDR) begin
            sel_d = mm_pkg::SEL_DEBUG;
        end
    end

    // grant everything, unmapped included
    assign bus.gnt = bus.req;

    // RAM only sees its own window
    assign mem.en    = bus.req && (sel_d == mm_pkg::SEL_RAM);
    assign mem.we    = bus.we;
    assign mem.be    = bus.be;
    assign mem.addr  = bus.addr[RAM_ADDR_WIDTH-1:2];
    assign mem.wdata = bus.wdata;

    // peripheral write strobe, unmapped writes dropped here
    assign per_wr_o    = bus.req && bus.we &&
                         (sel_d != mm_pkg::SEL_RAM) && (sel_d != mm_pkg::SEL_NONE);
    assign per_sel_o   = sel_d;
    assign per_wdata_o = bus.wdata;

    // response stage control
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rvalid_q <= 1'b0;
            sel_q    <= mm_pkg::SEL_NONE;
        end else begin
            rvalid_q <= bus.req;
            if (bus.req) begin
                sel_q <= sel_d;
            end
        end
    end

    // peripheral value as seen at accept
    always_ff @(posedge clk_i) begin
        if (bus.req) begin
            per_rdata_q <= per_rdata_i;
        end
    end

    assign bus.rvalid = rvalid_q;

    // response mux
    always_comb begin
        case (sel_q)
            mm_pkg::SEL_RAM:  bus.rdata = mem.rdata;
            mm_pkg::SEL_NONE: bus.rdata = '0;
            default:          bus.rdata = per_rdata_q;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/mm_instr_port.sv ====
// ****************************************
// instruction fetch handshake and read
// response
// ****************************************

`timescale 1ns/1ps
`default_nettype none

module mm_instr_port #(
    parameter int RAM_ADDR_WIDTH = 12
) (
    input logic clk_i,
    input logic rst_n_i,
    mm_bus_if.slave bus,
    mm_sram_if.ctrl mem
);

    // response stage flag
    logic rvalid_q;

    // every request granted right away, also in reset
    assign bus.gnt = bus.req;

    // read the word holding the byte address, high bits alias
    assign mem.en    = bus.req;
    assign mem.addr  = bus.addr[RAM_ADDR_WIDTH-1:2];
    // fetch never writes
    assign mem.we    = 1'b0;
    assign mem.be    = '0;
    assign mem.wdata = '0;

    // rvalid one cycle after grant
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= bus.req;
        end
    end

    assign bus.rvalid = rvalid_q;
    // RAM output already lines up with rvalid
    assign bus.rdata  = mem.rdata;

endmodule

`default_nettype wire

// ==== logic/mm_sram.sv ====
// ****************************************
// dual port word RAM, byte lane writes on
// data side, read only instruction side
// ****************************************

`timescale 1ns/1ps
`default_nettype none

module mm_sram #(
    parameter int RAM_ADDR_WIDTH = 12
) (
    input logic clk_i,
    mm_sram_if.mem i_port,
    mm_sram_if.mem d_port
);

    // number of 32 bit words
    localparam int WORDS = 2 ** (RAM_ADDR_WIDTH - 2);

    // storage, no reset on contents
    logic [31:0] mem_q [0:WORDS-1];

    // instruction side, registered read
    // same edge data write lands later, so fetch sees old word
    always_ff @(posedge clk_i) begin
        if (i_port.en) begin
            i_port.rdata <= mem_q[i_port.addr];
        end
    end

    // data side, read first then byte lane update
    always_ff @(posedge clk_i) begin
        if (d_port.en) begin
            d_port.rdata <= mem_q[d_port.addr];
            if (d_port.we) begin
                for (int b = 0; b < 4; b++) begin
                    // only enabled lanes change
                    if (d_port.be[b]) begin
                        mem_q[d_port.addr][8*b +: 8] <= d_port.wdata[8*b +: 8];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/mm_ifs.sv ====
// ****************************************
// mm bus port interface and RAM port
// interface, with their modports
// ****************************************

`timescale 1ns/1ps
`default_nettype none

// one req / gnt / rvalid bus port
interface mm_bus_if;

    logic          req;
    logic          gnt;
    logic          rvalid;
    mm_pkg::word_t addr;
    logic          we;
    mm_pkg::be_t   be;
    mm_pkg::word_t wdata;
    mm_pkg::word_t rdata;

    // requester side
    modport master (
        output req, addr, we, be, wdata,
        input  gnt, rvalid, rdata
    );

    // responder side, gnt combinational from req
    modport slave (
        input  req, addr, we, be, wdata,
        output gnt, rvalid, rdata
    );

endinterface

// one synchronous RAM port, word addressed
interface mm_sram_if #(
    parameter int RAM_ADDR_WIDTH = 12
);

    logic                      en;
    logic                      we;
    mm_pkg::be_t               be;
    // word index, byte offset bits dropped
    logic [RAM_ADDR_WIDTH-3:0] addr;
    mm_pkg::word_t             wdata;
    mm_pkg::word_t             rdata;

    // port controller
    modport ctrl (
        output en, we, be, addr, wdata,
        input  rdata
    );

    // memory array, rdata one cycle after en
    modport mem (
        input  en, we, be, addr, wdata,
        output rdata
    );

endinterface

`default_nettype wire

// ==== logic/mm_pkg.sv ====
// ****************************************
// address map, magic codes, target select
// and debug timer enums, bus word types
// ****************************************

`default_nettype none

package mm_pkg;

    // bus data and address word
    typedef logic [31:0] word_t;
    // one enable bit per byte lane
    typedef logic [3:0] be_t;

    // data port target
    typedef enum logic [2:0] {
        SEL_RAM,
        SEL_PRINT,
        SEL_STATUS,
        SEL_EXIT,
        SEL_DEBUG,
        SEL_NONE
    } sel_e;

    // debug request countdown
    typedef enum logic [1:0] {
        DBG_IDLE,
        DBG_COUNT,
        DBG_FIRE
    } dbg_state_e;

    // pseudo peripheral addresses
    localparam word_t PRINT_ADDR  = 32'h1000_0000;
    localparam word_t STATUS_ADDR = 32'h2000_0000;
    localparam word_t EXIT_ADDR   = 32'h2000_0004;
    localparam word_t DEBUG_ADDR  = 32'h1500_0000;

    // codes written to the status register
    localparam word_t TEST_PASS_MAGIC = 32'd123456789;
    localparam word_t TEST_FAIL_MAGIC = 32'd1;

endpackage

`default_nettype wire
